// File: uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

  // system clock and line rate
  localparam int CLK_FREQ_HZ = 50_000_000;
  localparam int BAUD_RATE   = 115_200;

  // clocks per bit, truncated to 434
  localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

  // receiver samples in the middle of each bit
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  // start, data, parity, stop
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // 1 = odd parity, 0 = even parity
  localparam bit ODD_PARITY = 1'b1;

endpackage

`default_nettype wire

// File: uart_types_pkg.sv
`default_nettype none

package uart_types_pkg;

  // host command, sent high byte first
  typedef logic [15:0] cmd_t;

  typedef logic [uart_cfg_pkg::DATA_BITS-1:0] byte_t;

  // bit 8 flags a parity error
  typedef logic [uart_cfg_pkg::DATA_BITS:0] read_word_t;

  // counts up to CLKS_PER_BIT - 1
  typedef logic [8:0] baud_cnt_t;

  // position inside an 11-bit frame
  typedef logic [3:0] bit_idx_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FRAME_HI,
    TX_FRAME_LO
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// File: uart_cmd_tx.sv
`default_nettype none

module uart_cmd_tx (
  input  wire                  clk,
  input  wire                  rst_n,
  input  uart_types_pkg::cmd_t cmd_in,
  input  wire                  cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx
);

  uart_types_pkg::tx_state_t state;
  uart_types_pkg::cmd_t      cmd_reg;
  uart_types_pkg::baud_cnt_t baud_cnt;
  uart_types_pkg::bit_idx_t  bit_idx;
  uart_types_pkg::bit_idx_t  nxt_idx;
  uart_types_pkg::byte_t     cur_byte;

  logic                                  parity_bit;
  logic [uart_cfg_pkg::FRAME_BITS-1:0]   frame;
  logic                                  accept;
  logic                                  bit_end;
  logic                                  stop_idx;
  logic                                  frame_end;
  logic                                  last_cycle;

  assign accept = cmd_vld && cmd_rdy;

  // high byte goes out first
  assign cur_byte = (state == uart_types_pkg::TX_FRAME_HI) ? cmd_reg[15:8] : cmd_reg[7:0];

  assign parity_bit = (^cur_byte) ^ uart_cfg_pkg::ODD_PARITY;

  // stop, parity, data LSB first, start
  assign frame = {1'b1, parity_bit, cur_byte, 1'b0};

  assign nxt_idx = bit_idx + 4'd1;

  assign bit_end = (baud_cnt ==
                    uart_types_pkg::baud_cnt_t'(uart_cfg_pkg::CLKS_PER_BIT - 1));

  assign stop_idx = (bit_idx ==
                     uart_types_pkg::bit_idx_t'(uart_cfg_pkg::FRAME_BITS - 1));

  assign frame_end = stop_idx && bit_end;

  // go idle one cycle early so the next start bit lands right after the stop bit
  assign last_cycle = (state == uart_types_pkg::TX_FRAME_LO) && stop_idx &&
                      (baud_cnt ==
                       uart_types_pkg::baud_cnt_t'(uart_cfg_pkg::CLKS_PER_BIT - 2));

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_reg <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_types_pkg::TX_IDLE;
      cmd_rdy  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else begin
      case (state)
        uart_types_pkg::TX_IDLE: begin
          if (accept) begin
            state    <= uart_types_pkg::TX_FRAME_HI;
            cmd_rdy  <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            // start bit of the high frame
            tx       <= 1'b0;
          end
        end
        uart_types_pkg::TX_FRAME_HI,
        uart_types_pkg::TX_FRAME_LO: begin
          if (last_cycle) begin
            state    <= uart_types_pkg::TX_IDLE;
            cmd_rdy  <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
          end else if (bit_end) begin
            baud_cnt <= '0;
            if (frame_end) begin
              // only reached from the high frame
              state   <= uart_types_pkg::TX_FRAME_LO;
              bit_idx <= '0;
              tx      <= 1'b0;
            end else begin
              bit_idx <= nxt_idx;
              tx      <= frame[nxt_idx];
            end
          end else begin
            baud_cnt <= baud_cnt + 9'd1;
          end
        end
        default: begin
          state   <= uart_types_pkg::TX_IDLE;
          cmd_rdy <= 1'b1;
          tx      <= 1'b1;
        end
      endcase
    end
  end

  // no new command while frames are on the line
  a_rdy_low_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state != uart_types_pkg::TX_IDLE) |-> !cmd_rdy
  ) else $error("cmd_rdy high while transmitting");

  a_tx_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == uart_types_pkg::TX_IDLE) |-> tx
  ) else $error("tx low while idle");

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        rx,
  output uart_types_pkg::read_word_t read_data,
  output logic                       read_rdy
);

  uart_types_pkg::rx_state_t state;
  uart_types_pkg::baud_cnt_t baud_cnt;
  uart_types_pkg::bit_idx_t  bit_idx;
  uart_types_pkg::byte_t     shift;

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic rx_fall;
  logic par_bit;
  logic parity_err;
  logic bit_end;
  logic half_end;
  logic last_data;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall = rx_prev && !rx_sync;

  assign bit_end = (baud_cnt ==
                    uart_types_pkg::baud_cnt_t'(uart_cfg_pkg::CLKS_PER_BIT - 1));

  assign half_end = (baud_cnt ==
                     uart_types_pkg::baud_cnt_t'(uart_cfg_pkg::HALF_BIT - 1));

  assign last_data = (bit_idx ==
                      uart_types_pkg::bit_idx_t'(uart_cfg_pkg::DATA_BITS - 1));

  // ones over data plus parity must match the configured sense
  assign parity_err = ((^shift) ^ par_bit) != uart_cfg_pkg::ODD_PARITY;

  // byte arrives LSB first
  always_ff @(posedge clk) begin
    if (state == uart_types_pkg::RX_DATA && bit_end) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if (state == uart_types_pkg::RX_PARITY && bit_end) begin
      par_bit <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_types_pkg::RX_IDLE;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        uart_types_pkg::RX_IDLE: begin
          // a falling edge also means the line went high after a bad frame
          if (rx_fall) begin
            state    <= uart_types_pkg::RX_START;
            baud_cnt <= '0;
          end
        end
        uart_types_pkg::RX_START: begin
          if (half_end) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            if (!rx_sync) begin
              state <= uart_types_pkg::RX_DATA;
            end else begin
              // glitch, not a start bit
              state <= uart_types_pkg::RX_IDLE;
            end
          end else begin
            baud_cnt <= baud_cnt + 9'd1;
          end
        end
        uart_types_pkg::RX_DATA: begin
          if (bit_end) begin
            baud_cnt <= '0;
            if (last_data) begin
              state <= uart_types_pkg::RX_PARITY;
            end else begin
              bit_idx <= bit_idx + 4'd1;
            end
          end else begin
            baud_cnt <= baud_cnt + 9'd1;
          end
        end
        uart_types_pkg::RX_PARITY: begin
          if (bit_end) begin
            baud_cnt <= '0;
            state    <= uart_types_pkg::RX_STOP;
          end else begin
            baud_cnt <= baud_cnt + 9'd1;
          end
        end
        uart_types_pkg::RX_STOP: begin
          if (read_rdy) begin
            state <= uart_types_pkg::RX_IDLE;
          end else if (bit_end) begin
            baud_cnt <= '0;
            if (rx_sync) begin
              read_data <= {parity_err, shift};
              read_rdy  <= 1'b1;
            end else begin
              // framing error, drop the byte
              state <= uart_types_pkg::RX_IDLE;
            end
          end else begin
            baud_cnt <= baud_cnt + 9'd1;
          end
        end
        default: state <= uart_types_pkg::RX_IDLE;
      endcase
    end
  end

  a_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  ) else $error("read_rdy held longer than one cycle");

  a_rdy_in_stop: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |-> (state == uart_types_pkg::RX_STOP)
  ) else $error("read_rdy outside the stop state");

endmodule

`default_nettype wire

// File: uart.sv
`default_nettype none

module uart (
  input  wire                        clk,
  input  wire                        rst_n,
  input  uart_types_pkg::cmd_t       cmd_in,
  input  wire                        cmd_vld,
  output logic                       cmd_rdy,
  output logic                       tx,
  input  wire                        rx,
  output uart_types_pkg::read_word_t read_data,
  output logic                       read_rdy
);

  // command path to the tx pin
  uart_cmd_tx u_cmd_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx      (tx)
  );

  // rx pin to read words, runs independently of the transmitter
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

`default_nettype wire

// File: tb_uart.sv
`default_nettype none

module tb_uart;

  localparam int CLKS = uart_cfg_pkg::CLKS_PER_BIT;

  logic clk;
  logic rst_n;
  uart_types_pkg::cmd_t cmd_in;
  logic cmd_vld;
  logic cmd_rdy;
  logic tx;
  logic rx;
  uart_types_pkg::read_word_t read_data;
  logic read_rdy;

  int cyc;
  int err_count;
  int check_count;
  int tx_done;
  int fall_cyc;
  logic prev_rdy;
  uart_types_pkg::cmd_t tx_items[$];
  uart_types_pkg::cmd_t exp_cmd[$];
  int exp_acc[$];
  logic [9:0] rx_items[$];
  int rx_exp[$];
  int exp_rd[$];

  uart DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic compare(input int got, input int exp, input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // odd parity from the count of ones
  function automatic logic odd_bit(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += b[i];
    return (ones % 2 == 0) ? 1'b1 : 1'b0;
  endfunction

  task automatic idle_gap();
    int n;
    n = ($urandom % 2) ? int'($urandom % 301) : 0;
    repeat (n) @(posedge clk);
  endtask

  task automatic read_frame(output logic [7:0] data, output int start);
    logic b;
    do @(negedge clk); while (tx !== 1'b0);
    start = cyc;
    repeat (uart_cfg_pkg::HALF_BIT) @(negedge clk);
    compare(tx, 0, "tx start bit");
    for (int k = 0; k < 10; k++) begin
      repeat (CLKS) @(negedge clk);
      b = tx;
      if (k < 8) data[k] = b;
      else if (k == 8) compare(b, odd_bit(data), "tx parity bit");
      else compare(b, 1, "tx stop bit");
    end
  endtask

  // rebuilds two frames per command and checks their start times
  initial begin : tx_monitor
    logic [7:0] hi;
    logic [7:0] lo;
    int s_hi;
    int s_lo;
    forever begin
      read_frame(hi, s_hi);
      read_frame(lo, s_lo);
      compare(s_lo, s_hi + 11 * CLKS, "low frame start cycle");
      if (exp_cmd.size() == 0) begin
        err_count++;
        $display("tx sent a command that was never accepted");
      end else begin
        compare({hi, lo}, exp_cmd.pop_front(), "tx command word");
        compare(s_hi, exp_acc.pop_front(), "high frame start cycle");
      end
      tx_done++;
    end
  end

  // ready falls after acceptance and comes back for the next one
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_rdy && !cmd_rdy) begin
        fall_cyc = cyc;
        if (exp_acc.size() == 0) begin
          err_count++;
          $display("cmd_rdy fell at %0t with no command accepted", $time);
        end else begin
          compare(fall_cyc, exp_acc[$], "cmd_rdy fall cycle");
        end
      end
      if (!prev_rdy && cmd_rdy) compare(cyc, fall_cyc + 22 * CLKS - 1, "cmd_rdy rise cycle");
    end
    prev_rdy = cmd_rdy;
  end

  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      if (exp_rd.size() == 0) begin
        err_count++;
        $display("read_rdy pulsed with no frame expected at %0t", $time);
      end else begin
        compare(read_data, exp_rd.pop_front(), "read word");
      end
    end
  end

  task automatic drive_commands();
    int prev_acc;
    int acc;
    int n;
    prev_acc = -1;
    foreach (tx_items[i]) begin
      n = ($urandom % 2) ? int'($urandom % 301) : 0;
      repeat (n) @(posedge clk);
      @(posedge clk);
      #2;
      cmd_in = tx_items[i];
      cmd_vld = 1'b1;
      do @(negedge clk); while (!cmd_rdy);
      acc = cyc + 1;
      exp_cmd.push_back(tx_items[i]);
      exp_acc.push_back(acc);
      if (n == 0 && prev_acc >= 0) compare(acc, prev_acc + 22 * CLKS, "back-to-back accept");
      prev_acc = acc;
      @(posedge clk);
      #2;
      cmd_vld = 1'b0;
    end
  endtask

  task automatic drive_frames();
    logic [10:0] fb;
    foreach (rx_items[i]) begin
      idle_gap();
      fb = {~rx_items[i][8], odd_bit(rx_items[i][7:0]) ^ rx_items[i][9],
            rx_items[i][7:0], 1'b0};
      if (rx_exp[i] >= 0) exp_rd.push_back(rx_exp[i]);
      @(posedge clk);
      #2;
      for (int k = 0; k < 11; k++) begin
        rx = fb[k];
        repeat (CLKS) @(posedge clk);
        #2;
      end
      rx = 1'b1;
      // line must be seen high again after a framing error
      if (rx_items[i][8]) repeat (CLKS) @(posedge clk);
    end
  endtask

  task automatic load_items(output bit ok);
    int fd;
    string kind;
    string ex;
    string line;
    int v;
    int p;
    int s;
    ok = 1'b1;
    fd = $fopen("uart_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open uart_testdata.txt");
      ok = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "t") begin
          void'($fscanf(fd, "%h", v));
          tx_items.push_back(v[15:0]);
        end else if (kind == "r") begin
          void'($fscanf(fd, "%h %d %d %s", v, p, s, ex));
          rx_items.push_back({p[0], s[0], v[7:0]});
          if (ex == "none") begin
            rx_exp.push_back(-1);
          end else if ($sscanf(ex, "%h", v) == 1) begin
            rx_exp.push_back(v);
          end else begin
            $display("unreadable expected read word %s in uart_testdata.txt", ex);
            ok = 1'b0;
          end
        end else begin
          void'($fgets(line, fd));
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    longint limit;
    bit loaded;
    void'($urandom(4442));
    cyc = 0;
    err_count = 0;
    check_count = 0;
    tx_done = 0;
    fall_cyc = 0;
    prev_rdy = 1'b1;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    load_items(loaded);
    if (!loaded) begin
      $display("TEST RESULT: FAIL");
    end else begin
      limit = longint'(tx_items.size() + rx_items.size()) * (22 * CLKS + 300 + 2 * CLKS);
      limit = (limit + 100 * CLKS) * 20 * 2;
      fork
        begin
          #(limit);
          $display("timeout: the test did not finish within %0d time units", limit);
          $display("TEST RESULT: FAIL");
          $finish;
        end
      join_none
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      compare(tx, 1, "tx after reset");
      compare(cmd_rdy, 1, "cmd_rdy after reset");
      compare(read_rdy, 0, "read_rdy after reset");
      fork
        drive_commands();
        drive_frames();
      join
      while (exp_cmd.size() != 0 || exp_rd.size() != 0) @(negedge clk);
      repeat (20 * CLKS) @(negedge clk);
      compare(tx_done, tx_items.size(), "commands sent on tx");
      $display("checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
uart_cfg_pkg.sv
uart_types_pkg.sv
uart_cmd_tx.sv
uart_rx.sv
uart.sv
tb_uart.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_uart
RTL_TOP   ?= uart
FILELIST  ?= filelist.f
PASS_MSG  ?= TEST RESULT: PASS
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		uart_cfg_pkg.sv uart_types_pkg.sv uart_cmd_tx.sv uart_rx.sv uart.sv

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) uart_testdata.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: uart_testdata.txt
# t <command hex>
# r <byte hex> <parity corrupt> <stop corrupt> <expected read word hex or none>
t 1234
r a5 0 0 0a5
t 00ff
r 00 0 0 000
t ffff
r ff 0 0 0ff
t 8001
r 3c 1 0 13c
t a55a
r 7e 0 1 none
r 81 0 0 081
t 0000
r 55 0 0 055
t 7f80
r aa 1 0 1aa
t c3c3
r 01 0 1 none
r 80 0 0 080
t 0f0f
r 96 0 0 096
t 5a5a
r 00 1 0 100
t e001
r ff 1 1 none
r 42 0 0 042
t 0102
r 24 0 0 024
t fe7f
